/* dv/controlpath_cases.txt */
// Fields op_keysize_encrypt_hold_latency, all hex; op 0 key, 1 plaintext, 2 key+plaintext, f end
// hold = cycles of i_ready low with o_valid up; latency = cycles after the accept cycle
0_0_1_00_04 // 128-bit key, encrypt
1_0_0_00_12 // 18 rounds, ready at once
1_0_0_02_12
0_0_0_00_04 // 128-bit key, decrypt
1_0_0_00_12
1_0_0_05_12
0_1_1_00_06 // 192-bit key, encrypt
1_0_0_00_18 // 24 rounds
1_0_0_03_18
0_2_0_00_06 // 256-bit key, decrypt
1_0_0_01_18
2_0_1_00_04 // key and plaintext valid together
1_0_0_00_12
0_3_1_00_06 // code 3 runs as a long key
1_0_0_04_18
2_3_0_00_06
1_0_0_00_18
0_0_1_00_04
0_2_1_00_06 // key right after key
1_0_0_07_18
f_0_0_00_00 // end of cases

/* files.f */
common/camellia_ctrl_pkg.sv
verilog/camellia_sequencer.sv
verilog/camellia_key_sched_decode.sv
verilog/camellia_data_round_decode.sv
verilog/camellia_controlpath.sv
dv/camellia_controlpath_assert.sv
dv/camellia_controlpath_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the control-path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module camellia_controlpath_tb -Mdir obj_dir -o camellia_controlpath_sim \
    -f files.f
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

./obj_dir/camellia_controlpath_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    echo "run_sim: pass"
    exit 0
fi
echo "run_sim: fail"
exit 1

/* dv/camellia_controlpath_tb.sv */
`default_nettype none

module camellia_controlpath_tb
    import camellia_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic        i_clk;
    logic        i_reset_n;
    logic        i_kvalid;
    logic        i_pvalid;
    logic        i_ready;
    logic        i_encrypt;
    key_size_t   i_key_size;
    logic        o_kready;
    logic        o_pready;
    logic        o_valid;
    ctrl_word_t  o_ctrl;
    key_size_t   o_key_size;
    logic        o_encrypt;

    // Case word holds op, key size, direction, ready hold and latency
    logic [27:0] case_mem [0:63];
    logic [31:0] rng_state;
    key_size_t   cur_key_size;  // Key class of the last loaded key
    logic        cur_encrypt;

    camellia_controlpath camellia_controlpath_i (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_kvalid   (i_kvalid),
        .i_pvalid   (i_pvalid),
        .i_ready    (i_ready),
        .i_encrypt  (i_encrypt),
        .i_key_size (i_key_size),
        .o_kready   (o_kready),
        .o_pready   (o_pready),
        .o_valid    (o_valid),
        .o_ctrl     (o_ctrl),
        .o_key_size (o_key_size),
        .o_encrypt  (o_encrypt)
    );

    bind camellia_controlpath camellia_controlpath_assert ctrl_assert_i (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_valid   (o_valid),
        .i_kready  (o_kready),
        .i_ctrl    (o_ctrl)
    );

    always #2 i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////
    // Helpers and compare tasks
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at %0d ns: %s expected %0b got %0b",
                                        $time, what, exp, got));
    endtask

    task automatic check_round(input string what, input round_idx_t got, input round_idx_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at %0d ns: %s expected %0d got %0d",
                                        $time, what, exp, got));
    endtask

    task automatic check_key_size(input string what, input key_size_t got, input key_size_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at %0d ns: %s expected %0d got %0d",
                                        $time, what, exp, got));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            stop_with_failure($sformatf("MISMATCH at %0d ns: %s expected %0d got %0d",
                                        $time, what, exp, got));
    endtask

    task automatic check_idle();
        check_bit("o_kready in idle", o_kready, 1'b1);
        check_bit("o_pready in idle", o_pready, 1'b1);
        check_bit("o_valid in idle", o_valid, 1'b0);
        check_bit("load_ka in idle", o_ctrl.load_ka, 1'b0);
        check_bit("load_kb in idle", o_ctrl.load_kb, 1'b0);
        check_bit("clear_d in idle", o_ctrl.clear_d, 1'b0);
        check_bit("load_ciphertext in idle", o_ctrl.load_ciphertext, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // Operations
    ////////////////////////////////////////////////////////////

    task automatic load_key(input key_size_t ks, input logic enc, input logic with_pt,
                            input int exp_lat);
        int n;
        int ka_seen;
        int kb_seen;
        ka_seen = 0;
        kb_seen = 0;
        @(posedge i_clk);
        #1;
        i_kvalid   = 1'b1;
        i_pvalid   = with_pt;  // Both valid and the key must win
        i_key_size = ks;
        i_encrypt  = enc;
        @(negedge i_clk);
        check_bit("o_kready on key accept", o_kready, 1'b1);
        check_bit("round-0 key path on accept", o_ctrl.sel_round0_in1, 1'b1);
        if (o_ctrl.load_ka)
            ka_seen++;
        @(posedge i_clk);
        #1;
        i_kvalid = 1'b0;
        i_pvalid = 1'b0;
        for (n = 1; n <= 40; n++)
        begin
            @(negedge i_clk);
            if (o_kready)
                break;
            check_bit("o_pready in key phase", o_pready, 1'b0);
            if (o_ctrl.load_ka)
                ka_seen++;
            if (o_ctrl.load_kb)
                kb_seen++;
        end
        if (n > 40)
            stop_with_failure("Timeout: o_kready did not come back after a key load");
        check_count("key phase latency", n, exp_lat);
        check_count("load_ka pulses", ka_seen, 1);
        check_count("load_kb pulses", kb_seen, (ks != 2'd0) ? 1 : 0);
        check_key_size("o_key_size", o_key_size, ks);
        check_bit("o_encrypt", o_encrypt, enc);
        cur_key_size = ks;
        cur_encrypt  = enc;
    endtask

    task automatic run_plaintext(input int hold, input int exp_lat);
        round_idx_t last;
        round_idx_t exp_key;
        int         n;
        int         h;
        int         lc_seen;
        int         lc_cycle;
        last     = (cur_key_size == 2'd0) ? 5'd17 : 5'd23;
        lc_seen  = 0;
        lc_cycle = -1;
        @(posedge i_clk);
        #1;
        i_pvalid = 1'b1;
        i_ready  = (hold == 0);
        @(negedge i_clk);
        check_bit("o_pready on plaintext accept", o_pready, 1'b1);
        check_round("sel_roundkey on accept", o_ctrl.sel_roundkey, cur_encrypt ? 5'd0 : last);
        @(posedge i_clk);
        #1;
        i_pvalid = 1'b0;
        for (n = 1; n <= 60; n++)
        begin
            @(negedge i_clk);
            if (o_valid)
                break;
            exp_key = cur_encrypt ? round_idx_t'(n) : round_idx_t'(int'(last) - n);
            check_round("sel_roundkey", o_ctrl.sel_roundkey, exp_key);
            check_bit("o_kready in data phase", o_kready, 1'b0);
            check_bit("o_pready in data phase", o_pready, 1'b0);
            if (o_ctrl.load_ciphertext)
            begin
                lc_seen++;
                lc_cycle = n;
            end
        end
        if (n > 60)
            stop_with_failure("Timeout: o_valid never rose after a plaintext was accepted");
        check_count("data phase latency", n, exp_lat);
        check_count("load_ciphertext pulses", lc_seen, 1);
        check_count("load_ciphertext cycle", lc_cycle, n - 1);

        // Result held while the consumer stalls
        for (h = 0; h < hold; h++)
        begin
            @(posedge i_clk);
            #1;
            if (h == hold - 1)
                i_ready = 1'b1;
            @(negedge i_clk);
            check_bit("o_valid under back-pressure", o_valid, 1'b1);
            check_bit("o_kready under back-pressure", o_kready, 1'b0);
            check_bit("o_pready under back-pressure", o_pready, 1'b0);
        end
        @(posedge i_clk);
        #1;
        i_ready = 1'b0;
        @(negedge i_clk);
        check_bit("o_valid after i_ready", o_valid, 1'b0);
        check_bit("o_kready after i_ready", o_kready, 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int          idx;
        int          gap;
        logic [27:0] entry;
        i_clk        = 1'b0;
        i_reset_n    = 1'b0;
        i_kvalid     = 1'b0;
        i_pvalid     = 1'b0;
        i_ready      = 1'b0;
        i_encrypt    = 1'b0;
        i_key_size   = '0;
        rng_state    = 32'h034915fb;
        cur_key_size = '0;
        cur_encrypt  = 1'b0;
        $readmemh("dv/controlpath_cases.txt", case_mem);

        repeat (8) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;
        @(negedge i_clk);
        check_idle();

        for (idx = 0; idx < 64; idx++)
        begin
            entry = case_mem[idx];
            if (entry[27:24] == 4'hf)
                break;
            case (entry[27:24])
                4'h0: load_key(entry[21:20], entry[16], 1'b0, int'(entry[7:0]));
                4'h1: run_plaintext(int'(entry[15:8]), int'(entry[7:0]));
                4'h2: load_key(entry[21:20], entry[16], 1'b1, int'(entry[7:0]));
                default: stop_with_failure($sformatf("Unknown operation in case %0d", idx));
            endcase
            rng_state = next_random(rng_state);
            gap       = int'(rng_state[1:0]);  // Zero to three idle cycles
            repeat (gap)
            begin
                @(posedge i_clk);
                #1;
                @(negedge i_clk);
                check_idle();
            end
        end
        if (idx == 64)
            stop_with_failure("The case file has no end marker");

        if (camellia_controlpath_i.ctrl_assert_i.fail_count == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
            stop_with_failure("A concurrent assertion failed during the run");
    end

endmodule

`default_nettype wire

/* dv/camellia_controlpath_assert.sv */
`default_nettype none

module camellia_controlpath_assert
    import camellia_ctrl_pkg::*;
(
    input logic       i_clk,
    input logic       i_reset_n,
    input logic       i_valid,
    input logic       i_kready,
    input ctrl_word_t i_ctrl
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    ////////////////////////////////////////////////////////////
    // Handshake and strobes
    ////////////////////////////////////////////////////////////

    valid_kready_excl: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_valid && i_kready))
    else
    begin
        fail_count = fail_count + 1;
        $error("o_valid and o_kready high together");
    end

    // KA is captured on a single round
    load_ka_single: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_ctrl.load_ka |=> !i_ctrl.load_ka)
    else
    begin
        fail_count = fail_count + 1;
        $error("load_ka held for more than one cycle");
    end

    ciphertext_then_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_ctrl.load_ciphertext |=> i_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("o_valid did not follow load_ciphertext");
    end

endmodule

`default_nettype wire

/* verilog/camellia_controlpath.sv */
`default_nettype none

module camellia_controlpath
    import camellia_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_kvalid,
    input  logic       i_pvalid,
    input  logic       i_ready,
    input  logic       i_encrypt,
    input  key_size_t  i_key_size,
    output logic       o_kready,
    output logic       o_pready,
    output logic       o_valid,
    output ctrl_word_t o_ctrl,
    output key_size_t  o_key_size,
    output logic       o_encrypt
);

    phase_t     w_phase;
    round_idx_t w_round;
    ctrl_word_t w_key_ctrl;
    ctrl_word_t w_data_ctrl;

    camellia_sequencer u_sequencer (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_kvalid   (i_kvalid),
        .i_pvalid   (i_pvalid),
        .i_ready    (i_ready),
        .i_encrypt  (i_encrypt),
        .i_key_size (i_key_size),
        .o_kready   (o_kready),
        .o_pready   (o_pready),
        .o_valid    (o_valid),
        .o_phase    (w_phase),
        .o_round    (w_round),
        .o_key_size (o_key_size),
        .o_encrypt  (o_encrypt)
    );

    camellia_key_sched_decode u_key_sched_decode (
        .i_round    (w_round),
        .i_key_size (o_key_size),
        .o_ctrl     (w_key_ctrl)
    );

    camellia_data_round_decode u_data_round_decode (
        .i_round    (w_round),
        .i_key_size (o_key_size),
        .i_encrypt  (o_encrypt),
        .o_ctrl     (w_data_ctrl)
    );

    ////////////////////////////////////////////////////////////
    // Control word select by phase
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (w_phase)
            PH_KEY:  o_ctrl = w_key_ctrl;
            PH_DATA: o_ctrl = w_data_ctrl;
            PH_DONE:
            begin
                o_ctrl         = CTRL_IDLE;
                o_ctrl.clear_d = 1'b1;  // D1/D2 cleared while the result waits
            end
            default: o_ctrl = CTRL_IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/camellia_data_round_decode.sv */
`default_nettype none

module camellia_data_round_decode
    import camellia_ctrl_pkg::*;
(
    input  round_idx_t i_round,
    input  key_size_t  i_key_size,
    input  logic       i_encrypt,
    output ctrl_word_t o_ctrl
);

    logic       w_long_key;
    round_idx_t w_last;
    round_idx_t w_roundkey;

    assign w_long_key = (i_key_size != KEY_SIZE_128);
    assign w_last     = w_long_key ? DATA_LAST_LONG : DATA_LAST_SHORT;

    // Decryption walks the round keys backwards
    assign w_roundkey = i_encrypt ? i_round : (w_last - i_round);

    always_comb
    begin
        o_ctrl                = CTRL_IDLE;
        o_ctrl.sel_roundkey   = w_roundkey;
        o_ctrl.sel_key_func_f = w_long_key ? 2'd2 : 2'd1;

        if (i_round == 5'd0)
        begin
            // Plaintext enters with pre-whitening
            o_ctrl.sel_next_d1   = 2'd3;
            o_ctrl.sel_next_d2   = 2'd0;
            o_ctrl.sel_whiten_d1 = 2'd1;
            o_ctrl.sel_whiten_d2 = 2'd1;
        end
        else if (i_round == FL_ROUND_A || i_round == FL_ROUND_B)
        begin
            ////////////////////////////////////////////////////////////
            // FL / FL^-1 layer
            ////////////////////////////////////////////////////////////
            o_ctrl.sel_next_d1 = 2'd1;
            o_ctrl.sel_next_d2 = 2'd2;
            if (i_round == FL_ROUND_A)
            begin
                o_ctrl.sel_fl    = w_long_key ? 3'd2 : 3'd0;
                o_ctrl.sel_flinv = w_long_key ? 3'd2 : 3'd0;
            end
            else
            begin
                o_ctrl.sel_fl    = w_long_key ? 3'd3 : 3'd1;
                o_ctrl.sel_flinv = w_long_key ? 3'd3 : 3'd1;
            end
        end
        else if (i_round == DATA_LAST_SHORT)
        begin
            // Last round for short keys and third FL layer for long keys
            o_ctrl.sel_next_d1     = w_long_key ? 2'd1 : 2'd3;
            o_ctrl.sel_next_d2     = w_long_key ? 2'd2 : 2'd0;
            o_ctrl.sel_fl          = FL_CODE_POST;
            o_ctrl.sel_flinv       = FL_CODE_POST;
            o_ctrl.sel_whiten_d1   = 2'd0;
            o_ctrl.sel_whiten_d2   = 2'd0;
            o_ctrl.sel_init_d1     = 2'd2;
            o_ctrl.sel_init_d2     = 2'd2;
            o_ctrl.sel_fout_0      = 1'b1;
            o_ctrl.load_ciphertext = !w_long_key;
        end
        else if (i_round == DATA_LAST_LONG)
        begin
            o_ctrl.sel_next_d1     = 2'd3;
            o_ctrl.sel_next_d2     = 2'd0;
            o_ctrl.sel_whiten_d1   = 2'd0;   // Post-whitening
            o_ctrl.sel_whiten_d2   = 2'd0;
            o_ctrl.sel_init_d1     = 2'd2;
            o_ctrl.sel_init_d2     = 2'd2;
            o_ctrl.sel_fout_0      = 1'b1;
            o_ctrl.load_ciphertext = w_long_key;
        end
        else if (i_round[0])
        begin
            o_ctrl.sel_next_d1 = 2'd2;       // Odd rounds
            o_ctrl.sel_next_d2 = 2'd3;
        end
        else
        begin
            o_ctrl.sel_next_d1 = 2'd0;       // Even rounds
            o_ctrl.sel_next_d2 = 2'd1;
        end
    end

endmodule

`default_nettype wire

/* verilog/camellia_key_sched_decode.sv */
`default_nettype none

module camellia_key_sched_decode
    import camellia_ctrl_pkg::*;
(
    input  round_idx_t i_round,
    input  key_size_t  i_key_size,
    output ctrl_word_t o_ctrl
);

    logic w_short_key;

    assign w_short_key = (i_key_size == KEY_SIZE_128);

    // F always uses the key-schedule constants here
    always_comb
    begin
        o_ctrl = CTRL_IDLE;
        case (i_round)
            5'd0:
            begin
                // Key halves straight into D1/D2 through the round-0 path
                o_ctrl.sel_next_d1    = 2'd3;
                o_ctrl.sel_next_d2    = 2'd0;
                o_ctrl.sel_whiten_d1  = 2'd2;
                o_ctrl.sel_whiten_d2  = 2'd2;
                o_ctrl.sel_init_d1    = 2'd1;
                o_ctrl.sel_init_d2    = 2'd1;
                o_ctrl.sel_round0_in1 = 1'b1;
                o_ctrl.sel_round0_in2 = 1'b1;
            end
            5'd1:
            begin
                o_ctrl.sel_next_d1   = 2'd3;
                o_ctrl.sel_next_d2   = 2'd0;
                o_ctrl.sel_whiten_d1 = 2'd3;
                o_ctrl.sel_whiten_d2 = 2'd3;
                o_ctrl.sel_init_d1   = 2'd2;
                o_ctrl.sel_init_d2   = 2'd2;
                o_ctrl.sel_fout_0    = 1'b1;  // Mix with F output
            end
            5'd2, 5'd4:
            begin
                o_ctrl.sel_next_d1 = 2'd0;    // Swap halves
                o_ctrl.sel_next_d2 = 2'd1;
            end
            5'd3:
            begin
                o_ctrl.load_ka       = 1'b1;
                o_ctrl.sel_next_d1   = w_short_key ? 2'd2 : 2'd3;
                o_ctrl.sel_next_d2   = w_short_key ? 2'd3 : 2'd0;
                o_ctrl.sel_whiten_d1 = 2'd2;
                o_ctrl.sel_whiten_d2 = 2'd2;
                o_ctrl.sel_init_d1   = 2'd2;
                o_ctrl.sel_init_d2   = 2'd2;
                o_ctrl.sel_fout_0    = 1'b1;
                o_ctrl.clear_d       = w_short_key;  // Short key ends here
            end
            5'd5:
            begin
                // Long keys only
                o_ctrl.load_kb     = 1'b1;
                o_ctrl.sel_next_d1 = 2'd2;
                o_ctrl.sel_next_d2 = 2'd3;
                o_ctrl.clear_d     = 1'b1;
            end
            default:
            begin
                o_ctrl = CTRL_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/camellia_sequencer.sv */
`default_nettype none

module camellia_sequencer
    import camellia_ctrl_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_kvalid,
    input  logic       i_pvalid,
    input  logic       i_ready,
    input  logic       i_encrypt,
    input  key_size_t  i_key_size,
    output logic       o_kready,
    output logic       o_pready,
    output logic       o_valid,
    output phase_t     o_phase,
    output round_idx_t o_round,
    output key_size_t  o_key_size,
    output logic       o_encrypt
);

    phase_t     r_state;
    phase_t     w_next_state;
    round_idx_t r_round;
    round_idx_t w_next_round;
    key_size_t  r_key_size;
    logic       r_encrypt;

    logic       w_idle;
    logic       w_key_accept;
    logic       w_data_accept;
    logic       w_long_key;
    round_idx_t w_key_last;
    round_idx_t w_data_last;

    ////////////////////////////////////////////////////////////
    // Acceptance and terminal rounds
    ////////////////////////////////////////////////////////////

    assign w_idle        = (r_state == PH_IDLE);
    assign w_key_accept  = w_idle && i_kvalid;
    assign w_data_accept = w_idle && i_pvalid && !i_kvalid;  // Key request has priority

    // Code 3 falls in with the long keys
    assign w_long_key  = (r_key_size != KEY_SIZE_128);
    assign w_key_last  = w_long_key ? KEY_LAST_LONG : KEY_LAST_SHORT;
    assign w_data_last = w_long_key ? DATA_LAST_LONG : DATA_LAST_SHORT;

    always_comb
    begin
        w_next_state = r_state;
        w_next_round = r_round;
        case (r_state)
            PH_IDLE:
            begin
                // Accept cycle is round 0, so the counter starts at 1
                if (w_key_accept)
                begin
                    w_next_state = PH_KEY;
                    w_next_round = 5'd1;
                end
                else if (w_data_accept)
                begin
                    w_next_state = PH_DATA;
                    w_next_round = 5'd1;
                end
            end
            PH_KEY:
            begin
                if (r_round == w_key_last)
                begin
                    w_next_state = PH_IDLE;
                    w_next_round = 5'd0;
                end
                else
                    w_next_round = r_round + 5'd1;
            end
            PH_DATA:
            begin
                if (r_round == w_data_last)
                begin
                    w_next_state = PH_DONE;
                    w_next_round = 5'd0;
                end
                else
                    w_next_round = r_round + 5'd1;
            end
            PH_DONE:
            begin
                w_next_round = 5'd0;
                if (i_ready)
                    w_next_state = PH_IDLE;  // Ciphertext taken
            end
            default:
            begin
                w_next_state = PH_IDLE;
                w_next_round = 5'd0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_state <= PH_IDLE;
            r_round <= 5'd0;
        end
        else
        begin
            r_state <= w_next_state;
            r_round <= w_next_round;
        end
    end

    // Key size and direction only change with a new key
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_key_size <= KEY_SIZE_128;
            r_encrypt  <= 1'b0;
        end
        else if (w_key_accept)
        begin
            r_key_size <= i_key_size;
            r_encrypt  <= i_encrypt;
        end
    end

    // Accept cycle already reports the phase it starts
    always_comb
    begin
        o_phase = r_state;
        if (w_key_accept)
            o_phase = PH_KEY;
        else if (w_data_accept)
            o_phase = PH_DATA;
    end

    assign o_round    = r_round;
    assign o_kready   = w_idle;
    assign o_pready   = w_idle;
    assign o_valid    = (r_state == PH_DONE);
    assign o_key_size = r_key_size;
    assign o_encrypt  = r_encrypt;

endmodule

`default_nettype wire

/* common/camellia_ctrl_pkg.sv */
`default_nettype none

package camellia_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and basic types
    ////////////////////////////////////////////////////////////

    localparam int ROUND_W    = 5;
    localparam int KEY_SIZE_W = 2;

    typedef logic [ROUND_W-1:0]    round_idx_t;  // Round number / round-key index
    typedef logic [KEY_SIZE_W-1:0] key_size_t;   // 0 is 128-bit and anything else long

    localparam key_size_t KEY_SIZE_128 = 2'd0;

    // Phase of the control FSM
    typedef enum logic [1:0] {
        PH_IDLE = 2'd0,
        PH_KEY  = 2'd1,
        PH_DATA = 2'd2,
        PH_DONE = 2'd3
    } phase_t;

    ////////////////////////////////////////////////////////////
    // Round constants
    ////////////////////////////////////////////////////////////

    localparam round_idx_t KEY_LAST_SHORT  = 5'd3;   // KA ready
    localparam round_idx_t KEY_LAST_LONG   = 5'd5;   // KB ready
    localparam round_idx_t DATA_LAST_SHORT = 5'd17;
    localparam round_idx_t DATA_LAST_LONG  = 5'd23;
    localparam round_idx_t FL_ROUND_A      = 5'd5;
    localparam round_idx_t FL_ROUND_B      = 5'd11;

    localparam logic [2:0] FL_CODE_POST = 3'd4;  // Last FL key slot / post-whitening

    // Control word towards the datapath
    typedef struct packed {
        logic [1:0] sel_key_func_f;
        logic [1:0] sel_next_d1;
        logic [1:0] sel_next_d2;
        logic [2:0] sel_fl;
        logic [2:0] sel_flinv;
        logic [1:0] sel_whiten_d1;
        logic [1:0] sel_whiten_d2;
        logic [1:0] sel_init_d1;
        logic [1:0] sel_init_d2;
        logic       sel_fout_0;
        logic       sel_round0_in1;
        logic       sel_round0_in2;
        round_idx_t sel_roundkey;
        logic       load_ka;
        logic       load_kb;
        logic       clear_d;
        logic       load_ciphertext;
    } ctrl_word_t;

    // Datapath holds its state with these selects
    localparam ctrl_word_t CTRL_IDLE = '{
        sel_key_func_f  : 2'd0,
        sel_next_d1     : 2'd0,
        sel_next_d2     : 2'd3,
        sel_fl          : 3'd0,
        sel_flinv       : 3'd0,
        sel_whiten_d1   : 2'd1,
        sel_whiten_d2   : 2'd0,
        sel_init_d1     : 2'd0,
        sel_init_d2     : 2'd0,
        sel_fout_0      : 1'b0,
        sel_round0_in1  : 1'b0,
        sel_round0_in2  : 1'b0,
        sel_roundkey    : 5'd0,
        load_ka         : 1'b0,
        load_kb         : 1'b0,
        clear_d         : 1'b0,
        load_ciphertext : 1'b0
    };

endpackage

`default_nettype wire
